/* hw/shifter_pkg.sv */
// Shared widths, CORDIC angle table and gain constant for the frequency shifter; import where needed
package shifter_pkg;

    // Sample and phase formats
    localparam int SAMPLE_W = 16;       // Signed I and Q components
    localparam int PHASE_W  = 16;       // 2^PHASE_W is one full turn

    // Longest micro-rotation chain the table covers
    localparam int CORDIC_ITERS = 10;

    // atan(2^-i) scaled so that 2^16 equals 2*pi
    localparam logic [0:CORDIC_ITERS-1][PHASE_W-1:0] ATAN_TABLE = {
        16'h2000,   // 45.000 deg
        16'h12E4,   // 26.565 deg
        16'h09FB,   // 14.036 deg
        16'h0511,   // 7.125 deg
        16'h028B,   // 3.576 deg
        16'h0146,   // 1.790 deg
        16'h00A3,   // 0.895 deg
        16'h0051,   // 0.448 deg
        16'h0029,   // 0.224 deg
        16'h0014    // 0.112 deg
    };

    // 1/K for K = 1.64676, in Q1.15
    localparam logic signed [15:0] INV_GAIN = 16'sh4DBA;

    // Credit and occupancy counters, up to 15
    localparam int CREDIT_W = 4;

endpackage

/* hw/cordic_core.sv */
// Combinational CORDIC rotator; turns one I/Q pair by a phase word, result carries the CORDIC gain
`timescale 1ns/1ps

module cordic_core
    import shifter_pkg::*;
#(
    parameter int ITERATIONS = 10       // Micro-rotations, at most CORDIC_ITERS
) (
    input  logic signed [SAMPLE_W-1:0] x_in,
    input  logic signed [SAMPLE_W-1:0] y_in,
    input  logic        [PHASE_W-1:0]  z_in,
    output logic signed [SAMPLE_W+1:0] x_out,   // Two extra bits for gain and diagonal growth
    output logic signed [SAMPLE_W+1:0] y_out
);

    localparam int XW = SAMPLE_W + 2;

    logic        [1:0]         quad;        // Quarter turns taken by exact pre-rotation
    logic        [PHASE_W-1:0] z_res;       // Residual, within +-45 deg
    logic signed [XW-1:0]      xe;
    logic signed [XW-1:0]      ye;

    logic signed [XW-1:0]      xs [ITERATIONS+1];
    logic signed [XW-1:0]      ys [ITERATIONS+1];
    logic signed [PHASE_W-1:0] zs [ITERATIONS+1];

    // Round to nearest quadrant: residual of 45 deg or more takes one more quarter turn
    assign quad  = z_in[PHASE_W-1 -: 2] + {1'b0, z_in[PHASE_W-3]};
    assign z_res = z_in - {quad, {(PHASE_W-2){1'b0}}};    // Wraps negative when rounded up

    assign xe = XW'(x_in);     // Sign extend before negation so -32768 survives
    assign ye = XW'(y_in);

    always_comb begin
        // Exact 90 deg steps by swap and negate
        case (quad)
            2'd0: begin
                xs[0] = xe;
                ys[0] = ye;
            end
            2'd1: begin
                xs[0] = -ye;
                ys[0] = xe;
            end
            2'd2: begin
                xs[0] = -xe;
                ys[0] = -ye;
            end
            default: begin
                xs[0] = ye;
                ys[0] = -xe;
            end
        endcase
        zs[0] = z_res;

        // Drive residual towards zero
        for (int i = 0; i < ITERATIONS; i++) begin
            if (!zs[i][PHASE_W-1]) begin            // Positive residual, turn CCW
                xs[i+1] = xs[i] - (ys[i] >>> i);
                ys[i+1] = ys[i] + (xs[i] >>> i);
                zs[i+1] = zs[i] - ATAN_TABLE[i];
            end else begin                          // Negative, turn CW
                xs[i+1] = xs[i] + (ys[i] >>> i);
                ys[i+1] = ys[i] - (xs[i] >>> i);
                zs[i+1] = zs[i] + ATAN_TABLE[i];
            end
        end
    end

    assign x_out = xs[ITERATIONS];   // Scaled by ~1.647
    assign y_out = ys[ITERATIONS];

endmodule

/* hw/phase_accum.sv */
// NCO phase accumulator; steps by the frequency word on every launched sample
`timescale 1ns/1ps

module phase_accum
    import shifter_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance,     // One step per launched sample
    input  logic [PHASE_W-1:0] freq_word,   // Held static while samples flow
    output logic [PHASE_W-1:0] phase        // Phase for the sample now at the FIFO head
);

    logic [PHASE_W-1:0] acc;

    // Modulo 2^PHASE_W, wrap is free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;              // First sample goes through unrotated
        end else if (advance) begin
            acc <= acc + freq_word;
        end
    end

    // Launched sample sees the value before the step
    assign phase = acc;

endmodule

/* hw/sample_fifo.sv */
// Input sample buffer, circular, filled by the source against granted input credits
`timescale 1ns/1ps

module sample_fifo
    import shifter_pkg::*;
#(
    parameter int FIFO_DEPTH = 4        // Equals the number of input credits
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic                       pop,
    input  logic signed [SAMPLE_W-1:0] wr_i,
    input  logic signed [SAMPLE_W-1:0] wr_q,
    output logic signed [SAMPLE_W-1:0] rd_i,    // Head, valid while not empty
    output logic signed [SAMPLE_W-1:0] rd_q,
    output logic                       empty,
    output logic                       full
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic signed [SAMPLE_W-1:0] mem_i [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] mem_q [FIFO_DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [CREDIT_W-1:0]        count;
    logic                       wr_en;
    logic                       rd_en;

    // Depth need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_i[wr_ptr] <= wr_i;
            mem_q[wr_ptr] <= wr_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CREDIT_W'(wr_en) - CREDIT_W'(rd_en);
        end
    end

    assign rd_i  = mem_i[rd_ptr];
    assign rd_q  = mem_q[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CREDIT_W'(FIFO_DEPTH));

    // Source overran its credits
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    // Control launched from an empty buffer
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* hw/gain_comp.sv */
// CORDIC gain removal; two register stages, multiply by 1/K then round and saturate
`timescale 1ns/1ps

module gain_comp
    import shifter_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic signed [SAMPLE_W+1:0] x_raw,   // CORDIC output, gain ~1.647
    input  logic signed [SAMPLE_W+1:0] y_raw,
    output logic signed [SAMPLE_W-1:0] out_i,
    output logic signed [SAMPLE_W-1:0] out_q
);

    localparam int PW = SAMPLE_W + 2 + 16;     // Raw width plus Q1.15 gain
    localparam int RW = PW - 15;               // After dropping the fraction

    localparam logic signed [RW-1:0] S_MAX = RW'((1 << (SAMPLE_W - 1)) - 1);
    localparam logic signed [RW-1:0] S_MIN = -RW'(1 << (SAMPLE_W - 1));

    logic signed [PW-1:0] prod_x;       // Stage 1
    logic signed [PW-1:0] prod_y;
    logic signed [RW-1:0] rnd_x;
    logic signed [RW-1:0] rnd_y;

    // Stage 1 products
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_x <= '0;
            prod_y <= '0;
        end else begin
            prod_x <= x_raw * INV_GAIN;
            prod_y <= y_raw * INV_GAIN;
        end
    end

    // Half LSB added, then fraction dropped
    assign rnd_x = RW'((prod_x + PW'(1 << 14)) >>> 15);
    assign rnd_y = RW'((prod_y + PW'(1 << 14)) >>> 15);

    // Stage 2 clamps to sample range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_i <= '0;
            out_q <= '0;
        end else begin
            out_i <= (rnd_x > S_MAX) ? SAMPLE_W'(S_MAX) :
                     (rnd_x < S_MIN) ? SAMPLE_W'(S_MIN) : SAMPLE_W'(rnd_x);
            out_q <= (rnd_y > S_MAX) ? SAMPLE_W'(S_MAX) :
                     (rnd_y < S_MIN) ? SAMPLE_W'(S_MIN) : SAMPLE_W'(rnd_y);
        end
    end

endmodule

/* hw/shift_ctrl.sv */
// Credit control for both sides, launch decision and the two-cycle output valid pipe
`timescale 1ns/1ps

module shift_ctrl
    import shifter_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,      // Input credits granted at start-up
    parameter int OUT_CREDITS = 4       // Sink credits held after reset
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,      // Source push, one per credit
    input  logic out_credit,    // Sink returns one credit
    input  logic fifo_empty,
    input  logic fifo_full,
    output logic in_credit,     // One credit to source per pulse
    output logic launch,        // Pop, phase step and pipe entry
    output logic out_valid
);

    logic [CREDIT_W-1:0] grant_cnt;     // Input credits still owed to the source
    logic [CREDIT_W-1:0] out_cnt;       // Sink credits in hand
    logic [1:0]          vld;           // Bit 0 at product, bit 1 at rounded output

    // Needs a sample and somewhere to send it
    assign launch = !fifo_empty && (out_cnt != '0);

    // Owed count starts at FIFO_DEPTH, each pop owes one more
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_cnt <= CREDIT_W'(FIFO_DEPTH);
            in_credit <= 1'b0;
        end else begin
            in_credit <= (grant_cnt != '0);     // Pay one per cycle
            grant_cnt <= grant_cnt + CREDIT_W'(launch) - CREDIT_W'(grant_cnt != '0);
        end
    end

    // Spent at launch, refilled by the sink
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= CREDIT_W'(OUT_CREDITS);
        end else begin
            out_cnt <= out_cnt - CREDIT_W'(launch) + CREDIT_W'(out_credit);
        end
    end

    // Tracks gain_comp's two stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[0], launch};
        end
    end

    assign out_valid = vld[1];

    // Sink never returns more than it was given
    a_out_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= CREDIT_W'(OUT_CREDITS));
    a_no_credit_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        out_credit |-> (out_cnt != CREDIT_W'(OUT_CREDITS)));
    // Source must hold a credit, so it cannot send into a full buffer
    a_no_send_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && fifo_full));

endmodule

/* hw/freq_shifter_top.sv */
// Frequency shifter top; credit-driven I/Q in, NCO-rotated I/Q out two cycles after launch
`timescale 1ns/1ps

module freq_shifter_top
    import shifter_pkg::*;
#(
    parameter int ITERATIONS  = 10,     // CORDIC micro-rotations
    parameter int FIFO_DEPTH  = 4,      // Input buffer depth and credit count
    parameter int OUT_CREDITS = 4       // Sink credits after reset
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic        [PHASE_W-1:0]  freq_word,   // Phase step per sample
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_i,
    input  logic signed [SAMPLE_W-1:0] in_q,
    input  logic                       out_credit,
    output logic                       in_credit,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] out_i,
    output logic signed [SAMPLE_W-1:0] out_q
);

    logic                       launch;
    logic                       fifo_empty;
    logic                       fifo_full;
    logic signed [SAMPLE_W-1:0] head_i;      // FIFO head into the rotator
    logic signed [SAMPLE_W-1:0] head_q;
    logic        [PHASE_W-1:0]  phase;
    logic signed [SAMPLE_W+1:0] rot_x;       // Rotated, still scaled by K
    logic signed [SAMPLE_W+1:0] rot_y;

    shift_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_credit(out_credit),
        .fifo_empty(fifo_empty),
        .fifo_full (fifo_full),
        .in_credit (in_credit),
        .launch    (launch),
        .out_valid (out_valid)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk  (clk),
        .rst_n(rst_n),
        .push (in_valid),
        .pop  (launch),
        .wr_i (in_i),
        .wr_q (in_q),
        .rd_i (head_i),
        .rd_q (head_q),
        .empty(fifo_empty),
        .full (fifo_full)
    );

    phase_accum u_nco (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (launch),
        .freq_word(freq_word),
        .phase    (phase)
    );

    cordic_core #(.ITERATIONS(ITERATIONS)) u_cordic (
        .x_in (head_i),
        .y_in (head_q),
        .z_in (phase),
        .x_out(rot_x),
        .y_out(rot_y)
    );

    gain_comp u_gain (
        .clk  (clk),
        .rst_n(rst_n),
        .x_raw(rot_x),
        .y_raw(rot_y),
        .out_i(out_i),
        .out_q(out_q)
    );

endmodule

/* tb/tb_freq_shifter.sv */
// Self-checking testbench for the frequency shifter; replays the testdata records under credit flow
`timescale 1ns/1ps

module tb_freq_shifter
    import shifter_pkg::*;
();

    localparam int ITERATIONS  = 10;
    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 4;
    localparam int NUM_REC     = 24;        // Records after the frequency word
    localparam int TOL         = 4;         // LSB slack for CORDIC error
    localparam int STARTUP_MAX = 20;        // Cycles allowed for start-up credits
    localparam int RUN_MAX     = 3000;      // Cycles allowed for the whole stream

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic        [PHASE_W-1:0]  freq_word;
    logic                       in_valid;
    logic signed [SAMPLE_W-1:0] in_i;
    logic signed [SAMPLE_W-1:0] in_q;
    logic                       out_credit;
    logic                       in_credit;
    logic                       out_valid;
    logic signed [SAMPLE_W-1:0] out_i;
    logic signed [SAMPLE_W-1:0] out_q;

    logic [SAMPLE_W-1:0] tdata [1 + 4*NUM_REC];    // Word 0 is freq_word

    int credit_total = 0;      // in_credit pulses seen
    int credits_held = 0;      // Source credits not yet spent
    int sent         = 0;
    int out_idx      = 0;      // Next record expected at the output
    int owed         = 0;      // Outputs the sink has not paid back
    int credit_ret   = 0;      // out_credit pulses driven
    int hold         = 0;      // Sink idle cycles left
    int cycles;
    bit started      = 1'b0;

    freq_shifter_top #(
        .ITERATIONS (ITERATIONS),
        .FIFO_DEPTH (FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .freq_word (freq_word),
        .in_valid  (in_valid),
        .in_i      (in_i),
        .in_q      (in_q),
        .out_credit(out_credit),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .out_i     (out_i),
        .out_q     (out_q)
    );

    always #20 clk = ~clk;     // 40 ns period

    // Column 0, 1 input pair; 2, 3 expected pair
    function automatic logic signed [SAMPLE_W-1:0] record_field(input int k, input int col);
        return $signed(tdata[1 + 4*k + col]);
    endfunction

    task automatic check_value(input int got, input int exp, input int tol, input string what);
        int diff;
        diff = (got > exp) ? got - exp : exp - got;
        if (diff > tol) begin
            $display("FAIL at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value(int'(out_valid), 0, 0, "out_valid during reset");
            check_value(int'(in_credit), 0, 0, "in_credit during reset");
        end else begin
            if (in_credit) begin
                credit_total++;
                credits_held++;
            end
            if (out_valid) begin
                check_value(int'(out_idx < NUM_REC), 1, 0, "output beyond last record");
                check_value(int'(out_i), int'(record_field(out_idx, 2)), TOL,
                            $sformatf("out_i of record %0d", out_idx));
                check_value(int'(out_q), int'(record_field(out_idx, 3)), TOL,
                            $sformatf("out_q of record %0d", out_idx));
                out_idx++;
                owed++;
                // Sink credits bound the outputs
                check_value(int'(out_idx <= OUT_CREDITS + credit_ret), 1, 0,
                            "outputs beyond sink credits");
                // At most two launches still in flight
                check_value(int'(credit_total <= FIFO_DEPTH + out_idx + 2), 1, 0,
                            "input credits beyond launches");
            end
        end
    end

    // Source, one record per held credit, random idle gaps
    always @(posedge clk) begin
        if (started && credits_held > 0 && sent < NUM_REC && ($urandom % 4) != 0) begin
            in_valid <= 1'b1;
            in_i     <= record_field(sent, 0);
            in_q     <= record_field(sent, 1);
            credits_held--;
            sent++;
        end else begin
            in_valid <= 1'b0;
        end
    end

    // Sink pays back after random delays, now and then a long stall
    always @(posedge clk) begin
        if (hold > 0) begin
            hold--;
            out_credit <= 1'b0;
        end else if (owed > 0) begin
            out_credit <= 1'b1;
            owed--;
            credit_ret++;
            hold = (($urandom % 6) == 0) ? 24 : int'($urandom % 3);
        end else begin
            out_credit <= 1'b0;
        end
    end

    initial begin
        $readmemh("tb/freq_shifter_testdata.txt", tdata);
        void'($urandom(32'h7842_9daf));
        rst_n      = 1'b0;
        freq_word  = tdata[0];      // Static for the whole run
        in_valid   = 1'b0;
        in_i       = '0;
        in_q       = '0;
        out_credit = 1'b0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Start-up grant
        cycles = 0;
        while (credit_total < FIFO_DEPTH) begin
            @(posedge clk);
            cycles++;
            if (cycles > STARTUP_MAX) stop_on_timeout("start-up input credits never arrived");
        end
        repeat (4) @(posedge clk);     // No extra grants before traffic
        check_value(credit_total, FIFO_DEPTH, 0, "start-up in_credit pulses");
        @(negedge clk);
        started = 1'b1;

        cycles = 0;
        while (out_idx < NUM_REC) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_MAX) stop_on_timeout("not all records came out");
        end

        repeat (3) @(posedge clk);
        check_value(sent, NUM_REC, 0, "records sent");
        check_value(credit_total, FIFO_DEPTH + NUM_REC, 0, "input credits granted in total");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tb/freq_shifter_testdata.txt */
// Line 1 freq_word, then one record per line
// in_i in_q expected_out_i expected_out_q, 16-bit two's complement hex
4000
03E8 0000 03E8 0000
04B0 02BC FD44 04B0
FA24 0320 05DC FCE0
0258 F8F8 F8F8 FDA8
0100 0640 0100 0640
0000 FC18 03E8 0000
02BC FB50 FD44 04B0
0320 05DC 05DC FCE0
F8F8 FDA8 F8F8 FDA8
0640 FF00 0100 0640
FC18 0000 03E8 0000
FB50 FD44 FD44 04B0
05DC FCE0 05DC FCE0
FDA8 0708 F8F8 FDA8
FF00 F9C0 0100 0640
0000 03E8 03E8 0000
FD44 04B0 FD44 04B0
FCE0 FA24 05DC FCE0
0708 0258 F8F8 FDA8
F9C0 0100 0100 0640
03E8 0000 03E8 0000
04B0 02BC FD44 04B0
FA24 0320 05DC FCE0
0258 F8F8 F8F8 FDA8

/* freq_shifter.f */
hw/shifter_pkg.sv
hw/cordic_core.sv
hw/phase_accum.sv
hw/sample_fifo.sv
hw/gain_comp.sv
hw/shift_ctrl.sv
hw/freq_shifter_top.sv
tb/tb_freq_shifter.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the frequency shifter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_freq_shifter \
    -f freq_shifter.f

./obj_dir/Vtb_freq_shifter
